// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_qspi_xip
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= build.f
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP OBJ_DIR LOG FLIST VFLAGS"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST)) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
qspi_cfg_pkg.sv
qspi_proto_pkg.sv
qspi_frame_if.sv
qspi_cfg_regs.sv
xip_req_decode.sv
qspi_shift_engine.sv
qspi_read_capture.sv
qspi_xip_top.sv
tb_qspi_checker.sv
tb_qspi_xip.sv

// ==== qspi_cfg_pkg.sv ====
package qspi_cfg_pkg;

  ////////////////////
  // field widths
  ////////////////////
  localparam int cfg_base_w  = 24;
  localparam int cfg_dummy_w = 6;

  localparam logic [cfg_dummy_w-1:0] cfg_dummy_rst = 6'd10;  // flash default

  // bit positions inside the 32-bit config word
  localparam int cfg_exit_bit = cfg_base_w;
  localparam int cfg_quad_bit = cfg_base_w + 1;

  // layout, msb first
  //   31:26 dummy | 25 quad | 24 exit | 23:0 base
  typedef struct packed {
    logic [cfg_dummy_w-1:0] dummy;
    logic                   quad;      // quad XIP enable
    logic                   exit_req;  // leave XIP on next fetch
    logic [cfg_base_w-1:0]  base;
  } cfg_word_t;

endpackage

// ==== qspi_cfg_regs.sv ====
module qspi_cfg_regs (
  input  logic                    clk_i,
  input  logic                    por_ni,
  input  logic [31:0]             cfg_wdata_i,
  input  logic                    cfg_we_i,
  input  logic                    exit_done_i,
  output qspi_cfg_pkg::cfg_word_t cfg_o
);

  qspi_cfg_pkg::cfg_word_t cfg_q;

  always_ff @(posedge clk_i or negedge por_ni) begin
    if (!por_ni) begin
      cfg_q.base     <= '0;
      cfg_q.quad     <= 1'b0;
      cfg_q.exit_req <= 1'b0;
      cfg_q.dummy    <= qspi_cfg_pkg::cfg_dummy_rst;
    end else if (cfg_we_i) begin
      cfg_q.base     <= cfg_wdata_i[qspi_cfg_pkg::cfg_base_w-1:0];
      cfg_q.exit_req <= cfg_wdata_i[qspi_cfg_pkg::cfg_exit_bit];
      cfg_q.quad     <= cfg_wdata_i[qspi_cfg_pkg::cfg_quad_bit];
      cfg_q.dummy    <= cfg_wdata_i[31 -: qspi_cfg_pkg::cfg_dummy_w];
    end else if (exit_done_i) begin
      cfg_q.exit_req <= 1'b0;  // exit sequence sent, back to normal xip
    end
  end

  assign cfg_o = cfg_q;

endmodule

// ==== qspi_frame_if.sv ====
interface qspi_frame_if;

  logic                                 start;     // one cycle
  qspi_proto_pkg::xfer_kind_t           kind;
  logic [31:0]                          tx_frame;  // shifted out msb first
  logic [qspi_cfg_pkg::cfg_dummy_w-1:0] dummy;

  modport decode (
    output start,
    output kind,
    output tx_frame,
    output dummy
  );

  modport engine (
    input start,
    input kind,
    input tx_frame,
    input dummy
  );

endinterface

// ==== qspi_proto_pkg.sv ====
package qspi_proto_pkg;

  ////////////////////
  // standard spi read
  ////////////////////
  localparam logic [7:0] spi_read_op = 8'h03;
  localparam int         spi_tx_bits = 32;  // opcode + 24 bit address
  localparam int         spi_rx_bits = 32;

  ////////////////////
  // quad xip read
  ////////////////////
  localparam int quad_tx_nib    = 8;  // 6 address, 2 mode
  localparam int quad_rx_nib    = 8;
  localparam int quad_exit_clks = 2;  // trailing clocks after dummy on exit

  // address nibbles zero, leading mode nibble 0001
  localparam logic [31:0] exit_pattern = 32'h0000_0010;

  // pin output enables, active low
  localparam logic [3:0] oe_spi      = 4'b1110;
  localparam logic [3:0] oe_quad_out = 4'b0000;
  localparam logic [3:0] oe_quad_in  = 4'b1111;

  typedef enum logic [1:0] {xfer_spi_rd, xfer_quad_rd, xfer_quad_exit} xfer_kind_t;

endpackage

// ==== qspi_read_capture.sv ====
module qspi_read_capture (
  input  logic                       clk_i,
  input  logic                       por_ni,
  input  logic [31:0]                rx_word_i,
  input  logic                       rx_done_i,
  input  qspi_proto_pkg::xfer_kind_t kind_i,
  output logic [31:0]                rdata_o,
  output logic                       rvalid_o
);

  logic rd_done;

  // exits return nothing
  assign rd_done = rx_done_i && (kind_i != qspi_proto_pkg::xfer_quad_exit);

  always_ff @(posedge clk_i or negedge por_ni) begin
    if (!por_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_done) begin
      rdata_o <= rx_word_i;  // held until next read
    end
  end

  a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (!por_ni)
    rvalid_o |=> !rvalid_o);

endmodule

// ==== qspi_shift_engine.sv ====
module qspi_shift_engine (
  input  logic         clk_i,
  input  logic         por_ni,
  qspi_frame_if.engine frame,
  input  logic [3:0]   qspi_i,
  output logic [3:0]   qspi_o,
  output logic [3:0]   qspi_oe_o,
  output logic         qspi_csb_o,
  output logic         qspi_clk_o,
  output logic         busy_o,
  output logic [31:0]  rx_word_o,
  output logic         rx_done_o,
  output logic         exit_done_o
);

  typedef enum logic [1:0] {st_idle, st_low, st_high, st_finish} eng_state_t;

  eng_state_t                           state_q;
  qspi_proto_pkg::xfer_kind_t           kind_q;
  logic [qspi_cfg_pkg::cfg_dummy_w-1:0] dummy_q;
  logic [6:0]                           cnt_q;  // rising serial edges so far
  logic [31:0]                          tx_q;
  logic [31:0]                          rx_q;
  logic [6:0]                           data_start;
  logic [6:0]                           last_cnt;
  logic                                 quad;

  assign quad = (kind_q != qspi_proto_pkg::xfer_spi_rd);

  ////////////////////
  // per-kind lengths
  ////////////////////
  always_comb begin
    data_start = 7'(qspi_proto_pkg::quad_tx_nib) + 7'(dummy_q);
    case (kind_q)
      qspi_proto_pkg::xfer_quad_rd: begin
        last_cnt = data_start + 7'(qspi_proto_pkg::quad_rx_nib);
      end
      qspi_proto_pkg::xfer_quad_exit: begin
        last_cnt = data_start + 7'(qspi_proto_pkg::quad_exit_clks);
      end
      default: begin
        data_start = 7'(qspi_proto_pkg::spi_tx_bits);
        last_cnt   = 7'(qspi_proto_pkg::spi_tx_bits + qspi_proto_pkg::spi_rx_bits);
      end
    endcase
  end

  ////////////////////
  // fsm
  ////////////////////
  always_ff @(posedge clk_i or negedge por_ni) begin
    if (!por_ni) begin
      state_q     <= st_idle;
      kind_q      <= qspi_proto_pkg::xfer_spi_rd;
      dummy_q     <= '0;
      cnt_q       <= '0;
      tx_q        <= '0;
      qspi_csb_o  <= 1'b1;
      qspi_clk_o  <= 1'b1;
      qspi_oe_o   <= qspi_proto_pkg::oe_spi;
      rx_done_o   <= 1'b0;
      exit_done_o <= 1'b0;
    end else begin
      rx_done_o   <= 1'b0;
      exit_done_o <= 1'b0;
      case (state_q)
        st_idle: begin
          if (frame.start) begin
            kind_q     <= frame.kind;
            dummy_q    <= frame.dummy;
            tx_q       <= frame.tx_frame;  // first bit valid as csb falls
            cnt_q      <= '0;
            qspi_csb_o <= 1'b0;
            qspi_oe_o  <= (frame.kind == qspi_proto_pkg::xfer_spi_rd) ?
                          qspi_proto_pkg::oe_spi : qspi_proto_pkg::oe_quad_out;
            state_q    <= st_low;
          end
        end
        st_low: begin
          qspi_clk_o <= 1'b0;
          if (cnt_q != '0) begin  // falling edge, advance data
            tx_q <= quad ? {tx_q[27:0], 4'b0000} : {tx_q[30:0], 1'b0};
          end
          if (kind_q == qspi_proto_pkg::xfer_quad_rd && cnt_q == data_start) begin
            qspi_oe_o <= qspi_proto_pkg::oe_quad_in;  // dummy done, flash drives
          end
          state_q <= st_high;
        end
        st_high: begin
          qspi_clk_o <= 1'b1;
          cnt_q      <= cnt_q + 7'd1;
          state_q    <= (cnt_q + 7'd1 == last_cnt) ? st_finish : st_low;
        end
        st_finish: begin
          qspi_csb_o  <= 1'b1;
          qspi_oe_o   <= qspi_proto_pkg::oe_spi;
          rx_done_o   <= (kind_q != qspi_proto_pkg::xfer_quad_exit);
          exit_done_o <= (kind_q == qspi_proto_pkg::xfer_quad_exit);
          state_q     <= st_idle;
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // sample on the rising serial edge
  always_ff @(posedge clk_i) begin
    if (state_q == st_high && cnt_q >= data_start) begin
      rx_q <= quad ? {rx_q[27:0], qspi_i} : {rx_q[30:0], qspi_i[1]};
    end
  end

  // wp and hold held high in spi mode
  assign qspi_o    = quad ? tx_q[31:28] : {2'b11, 1'b0, tx_q[31]};
  assign rx_word_o = rx_q;
  // keep decode off until the cleared exit bit is visible
  assign busy_o    = (state_q != st_idle) || exit_done_o;

  a_clk_in_frame: assert property (@(posedge clk_i) disable iff (!por_ni)
    $changed(qspi_clk_o) |-> !qspi_csb_o);

  a_done_excl: assert property (@(posedge clk_i) disable iff (!por_ni)
    !(rx_done_o && exit_done_o));

endmodule

// ==== qspi_xip_top.sv ====
module qspi_xip_top (
  input  logic        clk_i,
  input  logic        por_ni,
  input  logic [23:0] addr_i,
  input  logic        req_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  input  logic [31:0] cfg_wdata_i,
  input  logic        cfg_we_i,
  input  logic [3:0]  qspi_i,
  output logic [3:0]  qspi_o,
  output logic [3:0]  qspi_oe_o,
  output logic        qspi_csb_o,
  output logic        qspi_clk_o
);

  qspi_cfg_pkg::cfg_word_t cfg;
  logic                    busy;
  logic                    exit_done;
  logic                    rx_done;
  logic [31:0]             rx_word;

  qspi_frame_if frame_if ();

  qspi_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .por_ni      (por_ni),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_we_i    (cfg_we_i),
    .exit_done_i (exit_done),
    .cfg_o       (cfg)
  );

  xip_req_decode u_req_decode (
    .clk_i  (clk_i),
    .por_ni (por_ni),
    .addr_i (addr_i),
    .req_i  (req_i),
    .cfg_i  (cfg),
    .busy_i (busy),
    .frame  (frame_if.decode)
  );

  qspi_shift_engine u_shift_engine (
    .clk_i       (clk_i),
    .por_ni      (por_ni),
    .frame       (frame_if.engine),
    .qspi_i      (qspi_i),
    .qspi_o      (qspi_o),
    .qspi_oe_o   (qspi_oe_o),
    .qspi_csb_o  (qspi_csb_o),
    .qspi_clk_o  (qspi_clk_o),
    .busy_o      (busy),
    .rx_word_o   (rx_word),
    .rx_done_o   (rx_done),
    .exit_done_o (exit_done)
  );

  // frame kind stays stable until the next accepted request
  qspi_read_capture u_read_capture (
    .clk_i     (clk_i),
    .por_ni    (por_ni),
    .rx_word_i (rx_word),
    .rx_done_i (rx_done),
    .kind_i    (frame_if.kind),
    .rdata_o   (rdata_o),
    .rvalid_o  (rvalid_o)
  );

endmodule

// ==== tb_qspi_checker.sv ====
module tb_qspi_checker (
  input logic        clk_i,
  input logic        por_ni,
  input logic        rvalid_i,
  input logic [31:0] rdata_i,
  input logic        csb_i,
  input logic        sclk_i,
  input logic [3:0]  oe_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int          n_pass = 0;
  int          n_fail = 0;
  int          rv_cnt = 0;
  int          model_errs = 0;
  int          test_idx = 0;
  bit          active = 0;
  bit          want_data = 0;
  logic [31:0] exp_word = '0;
  logic [31:0] last_data = '0;

  // count every rvalid pulse while a test is open
  always @(posedge clk_i) begin
    if (por_ni && active && rvalid_i) begin
      rv_cnt++;
      last_data = rdata_i;
    end
  end

  task automatic model_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    model_errs++;
  endtask

  task automatic check_idle();
    if (csb_i !== 1'b1 || sclk_i !== 1'b1 || rvalid_i !== 1'b0 || oe_i !== 4'b1110) begin
      $display("** Error at %0t ns: idle pins wrong, csb %b clk %b rvalid %b oe %b",
               $time, csb_i, sclk_i, rvalid_i, oe_i);
      $display("reset state: FAILED");
      n_fail++;
    end else begin
      $display("reset state: ok");
      n_pass++;
    end
  endtask

  task automatic begin_test(input int idx, input bit data_expected, input logic [31:0] exp);
    test_idx   = idx;
    want_data  = data_expected;
    exp_word   = exp;
    rv_cnt     = 0;
    model_errs = 0;
    active     = 1;
  endtask

  task automatic end_test();
    bit ok;
    int exp_cnt;
    ok      = (model_errs == 0);
    exp_cnt = want_data ? 1 : 0;
    active  = 0;
    if (rv_cnt != exp_cnt) begin
      $display("** Error at %0t ns: test %0d saw %0d rvalid pulses, wanted %0d",
               $time, test_idx, rv_cnt, exp_cnt);
      ok = 0;
    end else if (want_data && last_data !== exp_word) begin
      $display("** Error at %0t ns: test %0d read %h, wanted %h",
               $time, test_idx, last_data, exp_word);
      ok = 0;
    end
    if (ok) n_pass++;
    else n_fail++;
    $display("test %0d: %s", test_idx, ok ? "ok" : "FAILED");
  endtask

  task automatic report();
    $display("%0d checks, %0d ok, %0d failed", n_pass + n_fail, n_pass, n_fail);
  endtask

endmodule

// ==== tb_qspi_xip.sv ====
module tb_qspi_xip;

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk_i = 0;
  logic        por_ni = 0;
  logic [23:0] addr_i = '0;
  logic        req_i = 0;
  logic [31:0] cfg_wdata_i = '0;
  logic        cfg_we_i = 0;
  logic [3:0]  qspi_i = 4'hf;
  logic [31:0] rdata_o;
  logic        rvalid_o;
  logic [3:0]  qspi_o;
  logic [3:0]  qspi_oe_o;
  logic        qspi_csb_o;
  logic        qspi_clk_o;

  int          pk[$];  // 0 read, 1 exit, 2 double req, 3 read on old config
  logic [31:0] pc[$];
  logic [23:0] po[$];
  logic [31:0] pe[$];
  bit          loaded = 0;
  logic [31:0] cur_cfg = '0;
  int          exp_dummy = 10;
  bit          exp_exit = 0;

  // flash model state
  int          rise_cnt = 0;
  bit          fl_quad = 0;
  bit          seen_in = 0;
  logic [31:0] fl_in = '0;
  logic [31:0] fl_word = '0;

  qspi_xip_top u_qspi_xip_top (.*);

  tb_qspi_checker u_checker (
    .clk_i (clk_i), .por_ni (por_ni), .rvalid_i (rvalid_o), .rdata_i (rdata_o),
    .csb_i (qspi_csb_o), .sclk_i (qspi_clk_o), .oe_i (qspi_oe_o)
  );

  initial begin
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////
  // flash model
  ////////////////////
  always @(negedge qspi_csb_o) begin
    rise_cnt = 0;
    seen_in  = 0;
  end

  always @(posedge qspi_clk_o) begin
    if (!qspi_csb_o) begin
      if (rise_cnt == 0) fl_quad = (qspi_oe_o == 4'b0000);
      if (fl_quad && rise_cnt < 8) fl_in = {fl_in[27:0], qspi_o};
      else if (!fl_quad && rise_cnt < 32) fl_in = {fl_in[30:0], qspi_o[0]};
      rise_cnt++;
      if (!fl_quad && rise_cnt == 32) begin
        if (fl_in[31:24] != 8'h03) u_checker.model_error("flash saw a bad spi opcode");
        fl_word = {8'h5a, fl_in[23:0]};
      end else if (fl_quad && rise_cnt == 8) begin
        if (fl_in[7:0] != (exp_exit ? 8'h10 : 8'h00))
          u_checker.model_error("flash saw the wrong mode byte");
        fl_word = {8'h5a, fl_in[31:8]};
      end
    end
  end

  // answer just after the falling serial edge once oe has settled
  always @(negedge qspi_clk_o) begin
    int k;
    #1;
    if (!qspi_csb_o && fl_quad && !exp_exit) begin
      if (qspi_oe_o == 4'b1111 && !seen_in) begin
        seen_in = 1;
        if (rise_cnt != 8 + exp_dummy) u_checker.model_error("data phase after wrong dummy count");
      end
      if (rise_cnt == 8 + exp_dummy && qspi_oe_o != 4'b1111)
        u_checker.model_error("pins still driven when the data phase starts");
      k = rise_cnt - (8 + exp_dummy);
      if (k >= 0 && k < 8) qspi_i = fl_word[31 - 4*k -: 4];
    end else if (!qspi_csb_o && !fl_quad && rise_cnt >= 32 && rise_cnt < 64) begin
      qspi_i = {2'b11, fl_word[63 - rise_cnt], 1'b1};  // miso on pin 1
    end
  end

  task automatic pulse_req(input logic [23:0] off);
    @(posedge clk_i);
    #2 addr_i = off;
    req_i = 1;
    @(posedge clk_i);
    #2 req_i = 0;
  endtask

  task automatic run_fetch(input int idx);
    int n;
    int tail;
    if (pk[idx] != 3) begin
      cur_cfg = pc[idx];
      @(posedge clk_i);
      #2 cfg_wdata_i = cur_cfg;
      cfg_we_i = 1;
      @(posedge clk_i);
      #2 cfg_we_i = 0;
    end
    exp_dummy = int'(cur_cfg[31:26]);
    exp_exit  = (pk[idx] == 1);
    u_checker.begin_test(idx, pk[idx] != 1, pe[idx]);
    pulse_req(po[idx]);
    if (pk[idx] == 2) begin
      repeat (10) @(posedge clk_i);
      pulse_req(po[idx]);  // lands mid transfer
    end
    if (pk[idx] == 1) begin
      repeat (180) @(posedge clk_i);
    end else begin
      n = 0;
      while (!rvalid_o && n < 250) begin
        @(negedge clk_i);
        n++;
      end
      // a queued second request needs a whole spi frame to show up
      tail = (pk[idx] == 2) ? 150 : 10;
      repeat (tail) @(posedge clk_i);
    end
    u_checker.end_test();
  endtask

  initial begin
    int          fd;
    int          r;
    int          k;
    logic [31:0] c;
    logic [31:0] o;
    logic [31:0] e;
    string       line;
    fd = $fopen("xip_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file xip_patterns.txt");
      $display("test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        r = $fgets(line, fd);
        if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h", k, c, o, e) == 4) begin
            pk.push_back(k);
            pc.push_back(c);
            po.push_back(o[23:0]);
            pe.push_back(e);
          end
        end
      end
      $fclose(fd);
      loaded = 1;
      repeat (3) @(posedge clk_i);
      #2 por_ni = 1;
      @(negedge clk_i);
      u_checker.check_idle();
      foreach (pk[i]) run_fetch(i);
      u_checker.report();
      if (u_checker.n_fail == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (300 * pk.size() + 20) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", 300 * pk.size() + 20);
    $display("test failed");
    $finish;
  end

endmodule

// ==== xip_patterns.txt ====
# kind cfg offset expected, all hex
# kind 0 read, 1 exit, 2 double request, 3 read without config write
# cfg word is dummy[31:26] quad[25] exit[24] base[23:0]
0 28100000 000234 5a100234
0 28000000 abcdef 5aabcdef
0 2a200000 000010 5a200010
0 12003000 000ffc 5a003ffc
1 2b000000 000000 00000000
3 00000000 000100 5a000100
2 2a010000 000020 5a010020
2 28000000 123456 5a123456
0 12fffff0 000020 5a000010

// ==== xip_req_decode.sv ====
module xip_req_decode (
  input  logic                    clk_i,
  input  logic                    por_ni,
  input  logic [23:0]             addr_i,
  input  logic                    req_i,
  input  qspi_cfg_pkg::cfg_word_t cfg_i,
  input  logic                    busy_i,
  qspi_frame_if.decode            frame
);

  logic [qspi_cfg_pkg::cfg_base_w-1:0] fetch_addr;
  qspi_proto_pkg::xfer_kind_t          kind;
  logic [31:0]                         tx_frame;
  logic                                accept;

  assign fetch_addr = cfg_i.base + addr_i;
  assign accept     = req_i && !busy_i && !frame.start;  // drop while engine is running

  always_comb begin
    if (!cfg_i.quad) begin
      kind     = qspi_proto_pkg::xfer_spi_rd;
      tx_frame = {qspi_proto_pkg::spi_read_op, fetch_addr};
    end else if (cfg_i.exit_req) begin
      kind     = qspi_proto_pkg::xfer_quad_exit;
      tx_frame = qspi_proto_pkg::exit_pattern;
    end else begin
      kind     = qspi_proto_pkg::xfer_quad_rd;
      tx_frame = {fetch_addr, 8'h00};  // zero mode byte
    end
  end

  always_ff @(posedge clk_i or negedge por_ni) begin
    if (!por_ni) begin
      frame.start <= 1'b0;
    end else begin
      frame.start <= accept;
    end
  end

  // latched on accept and held until the next one
  always_ff @(posedge clk_i) begin
    if (accept) begin
      frame.kind     <= kind;
      frame.tx_frame <= tx_frame;
      frame.dummy    <= cfg_i.dummy;
    end
  end

  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!por_ni)
    frame.start |-> !busy_i);

endmodule
